// File: evp_sys.f
+incdir+source
source/evp_types_pkg.sv
source/evp_ctrl_pkg.sv
source/evp_tables.sv
source/evp_data_buffer.sv
source/evp_eval_fsm.sv
source/evp_cmd_port.sv
source/evp_sys.sv
bench/evp_sys_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing
LINT_FLAGS = --lint-only --timing
TOP = evp_sys_tb
RTL_TOP = evp_sys
FILELIST = evp_sys.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/evp_sys_tb.sv
`timescale 1ns/1ps

`include "evp_config.svh"

module evp_sys_tb
	import evp_types_pkg::*, evp_ctrl_pkg::*;
();

	localparam int N_RANDOM = 40;
	localparam int N_CMDS = 3 + 6 * 4 + N_RANDOM + 3;
	localparam int LOAD_CYCLES = `EVP_BUF_DEPTH + 3 * `EVP_SLOTS * (`EVP_COEFFS + 2) + 64;
	localparam int WATCHDOG_CYCLES = LOAD_CYCLES + N_CMDS * 60;

	logic clk;
	logic rst;
	logic req;
	slot_t slot;
	buf_addr_t sample_addr;
	logic ack;
	acc_t result;
	status_t status;
	logic coef_we;
	coeff_addr_t coef_waddr;
	coeff_t coef_wdata;
	logic deg_we;
	slot_t deg_waddr;
	deg_t deg_wdata;
	logic buf_we;
	buf_addr_t buf_waddr;
	sample_t buf_wdata;

	// mirrors of what was loaded into the DUT.
	coeff_t coef_ref [`EVP_SLOTS*`EVP_COEFFS];
	deg_t deg_ref [`EVP_SLOTS];
	sample_t samp_ref [`EVP_BUF_DEPTH];

	integer seed;
	acc_t exp_result;
	status_t exp_status;
	int n_checked;

	evp_sys UUT (
		.clk(clk),
		.rst(rst),
		.req(req),
		.slot(slot),
		.sample_addr(sample_addr),
		.ack(ack),
		.result(result),
		.status(status),
		.coef_we(coef_we),
		.coef_waddr(coef_waddr),
		.coef_wdata(coef_wdata),
		.deg_we(deg_we),
		.deg_waddr(deg_waddr),
		.deg_wdata(deg_wdata),
		.buf_we(buf_we),
		.buf_waddr(buf_waddr),
		.buf_wdata(buf_wdata)
	);

	always #5 clk = ~clk;

	// sum of ck * x^k over the slot, wrapping at 32 bits.
	function automatic acc_t poly_ref(input slot_t s, input sample_t x);
		int d;
		acc_t pw;
		acc_t sum;
		d = int'(deg_ref[s]);
		pw = 1;
		sum = '0;
		if (d > `EVP_MAX_DEG)
			return '0;
		for (int k = 0; k <= d; k++)
		begin
			sum = sum + acc_t'(coef_ref[int'(s) * `EVP_COEFFS + k]) * pw;
			pw = pw * acc_t'(x);
		end
		return sum;
	endfunction

	function automatic status_t status_ref(input slot_t s);
		if (int'(deg_ref[s]) > `EVP_MAX_DEG)
			return ST_BAD_DEG;
		else
			return ST_OK;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
		begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic write_coef(input int idx, input coeff_t val);
		@(posedge clk);
		#1;
		deg_we = 1'b0;
		buf_we = 1'b0;
		coef_we = 1'b1;
		coef_waddr = coeff_addr_t'(idx);
		coef_wdata = val;
		coef_ref[idx] = val;
	endtask

	task automatic write_deg(input int s, input deg_t val);
		@(posedge clk);
		#1;
		coef_we = 1'b0;
		buf_we = 1'b0;
		deg_we = 1'b1;
		deg_waddr = slot_t'(s);
		deg_wdata = val;
		deg_ref[s] = val;
	endtask

	task automatic write_sample(input int addr, input sample_t val);
		@(posedge clk);
		#1;
		coef_we = 1'b0;
		deg_we = 1'b0;
		buf_we = 1'b1;
		buf_waddr = buf_addr_t'(addr);
		buf_wdata = val;
		samp_ref[addr] = val;
	endtask

	task automatic release_loads();
		@(posedge clk);
		#1;
		coef_we = 1'b0;
		deg_we = 1'b0;
		buf_we = 1'b0;
	endtask

	task automatic program_slot(input int s, input int d);
		for (int k = 0; k < `EVP_COEFFS; k++)
			write_coef(s * `EVP_COEFFS + k, coeff_t'($random(seed)));
		write_deg(s, deg_t'(d));
		release_loads();
	endtask

	// full four-phase exchange, with req held a few extra cycles.
	task automatic run_command(input slot_t s, input buf_addr_t a);
		int extra;
		acc_t held_result;
		status_t held_status;
		extra = $random(seed) & 7;
		exp_result = poly_ref(s, samp_ref[a]);
		exp_status = status_ref(s);
		@(posedge clk);
		#1;
		slot = s;
		sample_addr = a;
		req = 1'b1;
		wait (ack === 1'b1);
		@(negedge clk);
		held_result = result;
		held_status = status;
		repeat (extra)
		begin
			@(negedge clk);
			check_value("ack", 32'(ack), 32'd1);
			check_value("result", result, held_result);
			check_value("status", status, held_status);
		end
		@(posedge clk);
		#1;
		req = 1'b0;
		@(negedge clk);
		check_value("ack", 32'(ack), 32'd1);
		wait (ack === 1'b0);
		@(negedge clk);
	endtask

	always
	begin
		@(posedge ack);
		@(negedge clk);
		check_value("result", result, exp_result);
		check_value("status", status, exp_status);
		n_checked++;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * 10);
		$display("Watchdog expired at %0t ns: no ack arrived in time", $time);
		$display("TEST FAILED");
		$fatal(1, "watchdog");
	end

	initial
	begin
		int s;
		int a;
		seed = 47518;
		n_checked = 0;
		clk = 1'b0;
		rst = 1'b0;
		req = 1'b0;
		slot = '0;
		sample_addr = '0;
		coef_we = 1'b0;
		coef_waddr = '0;
		coef_wdata = '0;
		deg_we = 1'b0;
		deg_waddr = '0;
		deg_wdata = '0;
		buf_we = 1'b0;
		buf_waddr = '0;
		buf_wdata = '0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b1;
		@(negedge clk);
		check_value("ack", 32'(ack), 32'd0);
		check_value("status", status, ST_BUSY);
		check_value("result", result, 32'd0);

		for (s = 0; s < `EVP_SLOTS; s++)
			deg_ref[s] = deg_t'(`EVP_DEG_UNSET);
		for (a = 0; a < `EVP_BUF_DEPTH; a++)
			write_sample(a, sample_t'($random(seed)));
		// x = 0, x = 1 and large values that wrap.
		write_sample(0, 16'h0000);
		write_sample(1, 16'h0001);
		write_sample(2, 16'hffff);
		write_sample(3, 16'hc35a);
		release_loads();
		program_slot(0, 0);
		program_slot(1, `EVP_MAX_DEG);
		for (s = 2; s < 6; s++)
			program_slot(s, $unsigned($random(seed)) % 11);
		// slot 7 stays unprogrammed.
		program_slot(6, `EVP_MAX_DEG + 1);

		run_command(slot_t'(7), buf_addr_t'(10));
		run_command(slot_t'(6), buf_addr_t'(2));
		run_command(slot_t'(1), buf_addr_t'(2));
		for (s = 0; s < 6; s++)
			for (a = 0; a < 4; a++)
				run_command(slot_t'(s), buf_addr_t'(a));

		program_slot(6, $unsigned($random(seed)) % 11);
		program_slot(7, `EVP_MAX_DEG);
		for (int n = 0; n < N_RANDOM; n++)
		begin
			s = $random(seed) & 7;
			a = $random(seed) & 1023;
			run_command(slot_t'(s), buf_addr_t'(a));
		end

		// rewrites between commands.
		program_slot(3, `EVP_MAX_DEG);
		run_command(slot_t'(3), buf_addr_t'(9));
		write_sample(5, sample_t'($random(seed)));
		release_loads();
		run_command(slot_t'(3), buf_addr_t'(5));
		run_command(slot_t'(1), buf_addr_t'(5));

		repeat (2) @(posedge clk);
		if (n_checked != N_CMDS)
		begin
			$display("Only %0d of %0d replies were compared", n_checked, N_CMDS);
			$display("TEST FAILED");
			$fatal(1, "reply count");
		end
		else
		begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

// File: source/evp_sys.sv
`timescale 1ns/1ps

module evp_sys
	import evp_types_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req,
	input slot_t slot,
	input buf_addr_t sample_addr,
	output logic ack,
	output acc_t result,
	output status_t status,
	input logic coef_we,
	input coeff_addr_t coef_waddr,
	input coeff_t coef_wdata,
	input logic deg_we,
	input slot_t deg_waddr,
	input deg_t deg_wdata,
	input logic buf_we,
	input buf_addr_t buf_waddr,
	input sample_t buf_wdata
);

	logic start;
	slot_t start_slot;
	buf_addr_t start_addr;
	logic done;
	acc_t eval_result;
	status_t eval_status;
	logic deg_rd_en;
	slot_t deg_raddr;
	deg_t deg_rdata;
	logic coef_rd_en;
	coeff_addr_t coef_raddr;
	coeff_t coef_rdata;
	logic buf_rd_en;
	buf_addr_t buf_raddr;
	sample_t buf_rdata;

	evp_cmd_port u_cmd_port (
		.clk(clk),
		.rst(rst),
		.req(req),
		.slot(slot),
		.sample_addr(sample_addr),
		.ack(ack),
		.result(result),
		.status(status),
		.start(start),
		.start_slot(start_slot),
		.start_addr(start_addr),
		.done(done),
		.eval_result(eval_result),
		.eval_status(eval_status)
	);

	evp_eval_fsm u_eval_fsm (
		.clk(clk),
		.rst(rst),
		.start(start),
		.start_slot(start_slot),
		.start_addr(start_addr),
		.deg_rd_en(deg_rd_en),
		.deg_raddr(deg_raddr),
		.deg_rdata(deg_rdata),
		.coef_rd_en(coef_rd_en),
		.coef_raddr(coef_raddr),
		.coef_rdata(coef_rdata),
		.buf_rd_en(buf_rd_en),
		.buf_raddr(buf_raddr),
		.buf_rdata(buf_rdata),
		.done(done),
		.eval_result(eval_result),
		.eval_status(eval_status)
	);

	evp_tables u_tables (
		.clk(clk),
		.rst(rst),
		.coef_we(coef_we),
		.coef_waddr(coef_waddr),
		.coef_wdata(coef_wdata),
		.coef_rd_en(coef_rd_en),
		.coef_raddr(coef_raddr),
		.coef_rdata(coef_rdata),
		.deg_we(deg_we),
		.deg_waddr(deg_waddr),
		.deg_wdata(deg_wdata),
		.deg_rd_en(deg_rd_en),
		.deg_raddr(deg_raddr),
		.deg_rdata(deg_rdata)
	);

	evp_data_buffer u_data_buffer (
		.clk(clk),
		.buf_we(buf_we),
		.buf_waddr(buf_waddr),
		.buf_wdata(buf_wdata),
		.buf_rd_en(buf_rd_en),
		.buf_raddr(buf_raddr),
		.buf_rdata(buf_rdata)
	);

endmodule

// File: source/evp_cmd_port.sv
`timescale 1ns/1ps

module evp_cmd_port
	import evp_types_pkg::*, evp_ctrl_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req,
	input slot_t slot,
	input buf_addr_t sample_addr,
	output logic ack,
	output acc_t result,
	output status_t status,
	output logic start,
	output slot_t start_slot,
	output buf_addr_t start_addr,
	input logic done,
	input acc_t eval_result,
	input status_t eval_status
);

	typedef enum logic [1:0] {cmd_wait, cmd_busy, cmd_reply} cmd_state_t;

	cmd_state_t state;
	logic take;

	assign take = (state == cmd_wait) && req && !ack;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= cmd_wait;
			ack <= 1'b0;
			start <= 1'b0;
			result <= '0;
			status <= ST_BUSY;
		end
		else
		begin
			start <= 1'b0;
			case (state)
				cmd_wait:
					if (take)
					begin
						start <= 1'b1;
						result <= '0;
						status <= ST_BUSY;
						state <= cmd_busy;
					end
				cmd_busy:
					if (done)
					begin
						result <= eval_result;
						status <= eval_status;
						ack <= 1'b1;
						state <= cmd_reply;
					end
				cmd_reply:
					// reply held as long as the requester keeps req up.
					if (!req)
					begin
						ack <= 1'b0;
						state <= cmd_wait;
					end
				default:
					state <= cmd_wait;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			start_slot <= slot;
			start_addr <= sample_addr;
		end
	end

endmodule

// File: source/evp_eval_fsm.sv
`timescale 1ns/1ps

`include "evp_config.svh"

module evp_eval_fsm
	import evp_types_pkg::*, evp_ctrl_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input slot_t start_slot,
	input buf_addr_t start_addr,
	output logic deg_rd_en,
	output slot_t deg_raddr,
	input deg_t deg_rdata,
	output logic coef_rd_en,
	output coeff_addr_t coef_raddr,
	input coeff_t coef_rdata,
	output logic buf_rd_en,
	output buf_addr_t buf_raddr,
	input sample_t buf_rdata,
	output logic done,
	output acc_t eval_result,
	output status_t eval_status
);

	eval_state_t state;
	slot_t slot_q;
	buf_addr_t addr_q;
	deg_t k;
	acc_t power;
	acc_t sum;

	// deg_rdata and buf_rdata hold their value for the whole run,
	// so neither the degree nor x is copied.
	assign deg_rd_en = (state == rd_deg);
	assign deg_raddr = slot_q;
	assign buf_rd_en = (state == rd_sample);
	assign buf_raddr = addr_q;
	assign coef_rd_en = (state == rd_sample) || (state == next_coeff);
	assign coef_raddr = coeff_addr_t'(slot_q * `EVP_COEFFS + k);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= idle;
			done <= 1'b0;
			eval_result <= '0;
			eval_status <= ST_BUSY;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				idle:
					if (start)
						state <= rd_deg;
				rd_deg:
					state <= check_deg;
				check_deg:
					// the unset marker is above the limit too.
					if (deg_rdata > `EVP_MAX_DEG)
						state <= fault;
					else
						state <= rd_sample;
				rd_sample:
					state <= accumulate;
				accumulate:
					if (k == deg_rdata)
						state <= finish;
					else
						state <= next_coeff;
				next_coeff:
					state <= step_power;
				step_power:
					state <= accumulate;
				finish:
				begin
					state <= idle;
					done <= 1'b1;
					eval_result <= sum;
					eval_status <= ST_OK;
				end
				fault:
				begin
					state <= idle;
					done <= 1'b1;
					eval_result <= '0;
					eval_status <= ST_BAD_DEG;
				end
				default:
					state <= idle;
			endcase
		end
	end

	// data path, all products wrap at the accumulator width.
	always_ff @(posedge clk)
	begin
		case (state)
			idle:
				if (start)
				begin
					slot_q <= start_slot;
					addr_q <= start_addr;
				end
			check_deg:
			begin
				k <= '0;
				power <= acc_t'(1);
				sum <= '0;
			end
			accumulate:
			begin
				sum <= sum + acc_t'(coef_rdata) * power;
				// k advances here so next_coeff reads c(k+1).
				if (k != deg_rdata)
					k <= k + 1'b1;
			end
			step_power:
				power <= power * acc_t'(buf_rdata);
			default:
				;
		endcase
	end

endmodule

// File: source/evp_data_buffer.sv
`timescale 1ns/1ps

`include "evp_config.svh"

module evp_data_buffer
	import evp_types_pkg::*;
(
	input logic clk,
	input logic buf_we,
	input buf_addr_t buf_waddr,
	input sample_t buf_wdata,
	input logic buf_rd_en,
	input buf_addr_t buf_raddr,
	output sample_t buf_rdata
);

	sample_t mem [`EVP_BUF_DEPTH];

	always_ff @(posedge clk)
	begin
		if (buf_we)
			mem[buf_waddr] <= buf_wdata;
	end

	// read data stays put between enabled reads.
	always_ff @(posedge clk)
	begin
		if (buf_rd_en)
			buf_rdata <= mem[buf_raddr];
	end

endmodule

// File: source/evp_tables.sv
`timescale 1ns/1ps

`include "evp_config.svh"

module evp_tables
	import evp_types_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic coef_we,
	input coeff_addr_t coef_waddr,
	input coeff_t coef_wdata,
	input logic coef_rd_en,
	input coeff_addr_t coef_raddr,
	output coeff_t coef_rdata,
	input logic deg_we,
	input slot_t deg_waddr,
	input deg_t deg_wdata,
	input logic deg_rd_en,
	input slot_t deg_raddr,
	output deg_t deg_rdata
);

	coeff_t coef_mem [`EVP_SLOTS*`EVP_COEFFS];
	deg_t deg_mem [`EVP_SLOTS];

	// coefficients, slot-major.
	always_ff @(posedge clk)
	begin
		if (coef_we)
			coef_mem[coef_waddr] <= coef_wdata;
		if (coef_rd_en)
			coef_rdata <= coef_mem[coef_raddr];
	end

	// every slot comes out of reset unprogrammed, so it faults until loaded.
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < `EVP_SLOTS; i++)
				deg_mem[i] <= deg_t'(`EVP_DEG_UNSET);
		end
		else if (deg_we)
			deg_mem[deg_waddr] <= deg_wdata;
	end

	always_ff @(posedge clk)
	begin
		if (deg_rd_en)
			deg_rdata <= deg_mem[deg_raddr];
	end

endmodule

// File: source/evp_ctrl_pkg.sv
package evp_ctrl_pkg;

	import evp_types_pkg::*;

	typedef enum logic [3:0] {
		idle,
		rd_deg,
		check_deg,
		rd_sample,
		accumulate,
		next_coeff,
		step_power,
		finish,
		fault
	} eval_state_t;

	localparam status_t ST_OK = '0;
	localparam status_t ST_BAD_DEG = status_t'(2);
	// no valid reply is held.
	localparam status_t ST_BUSY = '1;

endpackage

// File: source/evp_types_pkg.sv
package evp_types_pkg;

	`include "evp_config.svh"

	typedef logic [`EVP_DATA_W-1:0] sample_t;
	typedef logic [`EVP_DATA_W-1:0] coeff_t;

	// powers, partial sums and the final result share this width.
	typedef logic [`EVP_ACC_W-1:0] acc_t;

	typedef logic [$clog2(`EVP_SLOTS)-1:0] slot_t;
	// wide enough to hold the unset marker.
	typedef logic [$clog2(`EVP_DEG_UNSET+1)-1:0] deg_t;

	// flat index, slot * coeffs per slot + k.
	typedef logic [$clog2(`EVP_SLOTS*`EVP_COEFFS)-1:0] coeff_addr_t;
	typedef logic [`EVP_BUF_AW-1:0] buf_addr_t;

	typedef logic [`EVP_ACC_W-1:0] status_t;

endpackage

// File: source/evp_config.svh
`ifndef EVP_CONFIG_SVH
`define EVP_CONFIG_SVH

// polynomial storage.
`define EVP_SLOTS 8
`define EVP_COEFFS 11
`define EVP_MAX_DEG 10
// degree value of a slot that was never programmed.
`define EVP_DEG_UNSET 31

// sample buffer.
`define EVP_BUF_DEPTH 1024
`define EVP_BUF_AW 10

// data path widths.
`define EVP_DATA_W 16
`define EVP_ACC_W 32

`endif
